// ==== isaPkg.sv ====
/*
 * Instruction set of the 16-bit eight-register core.
 * Every word is 16 bits with the opcode in bits 15:11.
 * Opcodes that are not listed here decode as illegal.
 */
package isaPkg;

   localparam int DataWidth = 16;
   localparam int RegAddrWidth = 3;

   typedef enum logic [4:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      ADDI  = 5'b01000,
      SUBI  = 5'b01001,
      XORI  = 5'b01010,
      ANDNI = 5'b01011,
      SLBI  = 5'b10010,
      ROLI  = 5'b10100,
      SLLI  = 5'b10101,
      LBI   = 5'b11000,
      ALUR  = 5'b11011
   } opcode_t;

   // Function field of the register-register group
   typedef enum logic [1:0] {
      ADD  = 2'b00,
      SUB  = 2'b01,
      XOR  = 2'b10,
      ANDN = 2'b11
   } aluFunc_t;

   typedef struct packed {
      opcode_t opcode;
      logic [RegAddrWidth-1:0] rs;
      logic [RegAddrWidth-1:0] rt;
      logic [RegAddrWidth-1:0] rd;
      aluFunc_t func;
   } rFormat_t;

   typedef struct packed {
      opcode_t opcode;
      logic [RegAddrWidth-1:0] rs;
      logic [RegAddrWidth-1:0] rd;
      logic [4:0] imm5;
   } iFormat_t;

   typedef struct packed {
      opcode_t opcode;
      logic [RegAddrWidth-1:0] rd;
      logic [7:0] imm8;
   } biFormat_t;

   // One instruction word seen through each of the three formats
   typedef union packed {
      rFormat_t r;
      iFormat_t i;
      biFormat_t bi;
   } instr_t;

endpackage

// ==== pipePkg.sv ====
/*
 * Pipeline bundles passed between the core's stages.
 * QueueDepth must be a power of two and equals the sender's starting credits.
 */
package pipePkg;

   localparam int QueueDepth = 4;
   localparam int QueuePtrWidth = $clog2(QueueDepth);
   localparam int QueueCountWidth = $clog2(QueueDepth + 1);

   typedef enum logic [2:0] {ADD, SUB, XOR, ANDN, ROL, SLL, PASSB, SLBI} aluOp_t;

   typedef struct packed {
      logic valid;
      aluOp_t aluOp;
      logic [isaPkg::DataWidth-1:0] opA;
      logic [isaPkg::DataWidth-1:0] opB;
      logic [isaPkg::RegAddrWidth-1:0] dest;
      logic regWrite;
      logic halt;
      logic illegal;
   } dxBundle_t;

   typedef struct packed {
      logic valid;
      logic regWrite;
      logic [isaPkg::RegAddrWidth-1:0] dest;
      logic [isaPkg::DataWidth-1:0] value;
      logic halt;
      logic illegal;
   } xrBundle_t;

   // Result of the instruction now in execute
   typedef struct packed {
      logic valid;
      logic [isaPkg::RegAddrWidth-1:0] dest;
      logic [isaPkg::DataWidth-1:0] value;
   } fwdPath_t;

   typedef struct packed {
      logic valid;
      logic [isaPkg::RegAddrWidth-1:0] regAddr;
      logic [isaPkg::DataWidth-1:0] data;
   } wbEvent_t;

endpackage

// ==== instrQueue.sv ====
/*
 * Credit-based instruction FIFO of pipePkg::QueueDepth entries.
 * The sender may push only while it holds a credit; a push into a full
 * queue is dropped and flagged. One cmdCredit pulse follows each pop.
 */
`timescale 1ns/1ps

module instrQueue (
   input  logic clk,
   input  logic rst,
   input  logic cmdPush,
   input  isaPkg::instr_t cmdInstr,
   input  logic pop,
   output logic headValid,
   output isaPkg::instr_t headInstr,
   output logic cmdCredit
);

   isaPkg::instr_t entries [pipePkg::QueueDepth];
   logic [pipePkg::QueuePtrWidth-1:0] wrPtr;
   logic [pipePkg::QueuePtrWidth-1:0] rdPtr;
   logic [pipePkg::QueueCountWidth-1:0] count;
   logic doPush;
   logic doPop;

   assign headValid = (count != '0);
   assign headInstr = entries[rdPtr];
   assign doPush = cmdPush && (count != pipePkg::QueueDepth);
   assign doPop = pop && headValid;

   always_ff @(posedge clk) begin
      if (doPush) begin
         entries[wrPtr] <= cmdInstr;
      end
   end

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (rst) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
         cmdCredit <= 1'b0;
      end else begin
         if (doPush) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (doPop) begin
            rdPtr <= rdPtr + 1'b1;
         end
         if (doPush && !doPop) begin
            count <= count + 1'b1;
         end else if (doPop && !doPush) begin
            count <= count - 1'b1;
         end
         cmdCredit <= doPop;
      end
   end

   // Sender pushed without holding a credit
   noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
      cmdPush |-> (count != pipePkg::QueueDepth))
      else $error("instrQueue: push while the queue is full");

endmodule

// ==== regFile.sv ====
/*
 * Eight 16-bit registers, all cleared by reset.
 * Reads are combinational and see a write made in the same cycle.
 */
`timescale 1ns/1ps

module regFile (
   input  logic clk,
   input  logic rst,
   input  logic [isaPkg::RegAddrWidth-1:0] rdAddrA,
   input  logic [isaPkg::RegAddrWidth-1:0] rdAddrB,
   output logic [isaPkg::DataWidth-1:0] rdDataA,
   output logic [isaPkg::DataWidth-1:0] rdDataB,
   input  logic wrEn,
   input  logic [isaPkg::RegAddrWidth-1:0] wrAddr,
   input  logic [isaPkg::DataWidth-1:0] wrData
);

   logic [isaPkg::DataWidth-1:0] regs [2**isaPkg::RegAddrWidth];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**isaPkg::RegAddrWidth; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Write-through covers the instruction two ahead in result
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== decode.sv ====
/*
 * Decodes the queue head and registers the bundle for execute.
 * Operands come from execute's forward path first, then the register file.
 * Popping stops for good once a HALT has been taken, until reset.
 */
`timescale 1ns/1ps

module decode (
   input  logic clk,
   input  logic rst,
   input  logic headValid,
   input  isaPkg::instr_t headInstr,
   input  logic halted,
   output logic pop,
   output logic [isaPkg::RegAddrWidth-1:0] rdAddrA,
   output logic [isaPkg::RegAddrWidth-1:0] rdAddrB,
   input  logic [isaPkg::DataWidth-1:0] rdDataA,
   input  logic [isaPkg::DataWidth-1:0] rdDataB,
   input  pipePkg::fwdPath_t fwd,
   output pipePkg::dxBundle_t dx
);

   logic haltSeen;
   logic [isaPkg::DataWidth-1:0] regA;
   logic [isaPkg::DataWidth-1:0] regB;
   logic [isaPkg::DataWidth-1:0] immS5;
   logic [isaPkg::DataWidth-1:0] immZ5;
   logic [isaPkg::DataWidth-1:0] immSh;
   logic [isaPkg::DataWidth-1:0] immS8;
   logic [isaPkg::DataWidth-1:0] immZ8;
   pipePkg::dxBundle_t dxNext;

   assign pop = headValid && !halted && !haltSeen;

   // Bits 10:8 hold rs in R and I formats and rd in SLBI, which reads it
   assign rdAddrA = headInstr.r.rs;
   assign rdAddrB = headInstr.r.rt;
   assign regA = (fwd.valid && fwd.dest == rdAddrA) ? fwd.value : rdDataA;
   assign regB = (fwd.valid && fwd.dest == rdAddrB) ? fwd.value : rdDataB;

   assign immS5 = {{(isaPkg::DataWidth-5){headInstr.i.imm5[4]}}, headInstr.i.imm5};
   assign immZ5 = {{(isaPkg::DataWidth-5){1'b0}}, headInstr.i.imm5};
   assign immSh = {{(isaPkg::DataWidth-4){1'b0}}, headInstr.i.imm5[3:0]};
   assign immS8 = {{(isaPkg::DataWidth-8){headInstr.bi.imm8[7]}}, headInstr.bi.imm8};
   assign immZ8 = {{(isaPkg::DataWidth-8){1'b0}}, headInstr.bi.imm8};

   always_comb begin
      dxNext = '0;
      dxNext.valid = pop;
      dxNext.opA = regA;
      dxNext.opB = regB;
      dxNext.dest = headInstr.i.rd;
      dxNext.regWrite = 1'b1;
      case (headInstr.r.opcode)
         isaPkg::ALUR: begin
            dxNext.dest = headInstr.r.rd;
            case (headInstr.r.func)
               isaPkg::ADD: dxNext.aluOp = pipePkg::ADD;
               isaPkg::SUB: dxNext.aluOp = pipePkg::SUB;
               isaPkg::XOR: dxNext.aluOp = pipePkg::XOR;
               default: dxNext.aluOp = pipePkg::ANDN;
            endcase
         end
         isaPkg::ADDI: begin
            dxNext.aluOp = pipePkg::ADD;
            dxNext.opB = immS5;
         end
         isaPkg::SUBI: begin
            dxNext.aluOp = pipePkg::SUB;
            dxNext.opB = immS5;
         end
         isaPkg::XORI: begin
            dxNext.aluOp = pipePkg::XOR;
            dxNext.opB = immZ5;
         end
         isaPkg::ANDNI: begin
            dxNext.aluOp = pipePkg::ANDN;
            dxNext.opB = immZ5;
         end
         isaPkg::ROLI: begin
            dxNext.aluOp = pipePkg::ROL;
            dxNext.opB = immSh;
         end
         isaPkg::SLLI: begin
            dxNext.aluOp = pipePkg::SLL;
            dxNext.opB = immSh;
         end
         isaPkg::LBI: begin
            dxNext.dest = headInstr.bi.rd;
            dxNext.aluOp = pipePkg::PASSB;
            dxNext.opB = immS8;
         end
         isaPkg::SLBI: begin
            dxNext.dest = headInstr.bi.rd;
            dxNext.aluOp = pipePkg::SLBI;
            dxNext.opB = immZ8;
         end
         isaPkg::NOP: dxNext.regWrite = 1'b0;
         isaPkg::HALT: begin
            dxNext.regWrite = 1'b0;
            dxNext.halt = 1'b1;
         end
         default: begin
            dxNext.regWrite = 1'b0;
            dxNext.illegal = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dx.valid <= 1'b0;
         dx.regWrite <= 1'b0;
         dx.halt <= 1'b0;
         dx.illegal <= 1'b0;
         haltSeen <= 1'b0;
      end else begin
         dx <= dxNext;
         if (pop && headInstr.r.opcode == isaPkg::HALT) begin
            haltSeen <= 1'b1;
         end
      end
   end

   // An illegal word must never reach the register file downstream
   noWriteOnIllegal: assert property (@(posedge clk) disable iff (rst)
      dx.valid |-> !(dx.regWrite && dx.illegal))
      else $error("decode: bundle has both regWrite and illegal set");

endmodule

// ==== execute.sv ====
/*
 * ALU, shifter and byte-immediate merge for one instruction per cycle.
 * Shift and rotate amounts use the low four bits of opB only.
 */
`timescale 1ns/1ps

module execute (
   input  logic clk,
   input  logic rst,
   input  pipePkg::dxBundle_t dx,
   output pipePkg::fwdPath_t fwd,
   output pipePkg::xrBundle_t xr
);

   logic [isaPkg::DataWidth-1:0] aluOut;
   logic [2*isaPkg::DataWidth-1:0] rotWide;
   logic [3:0] shAmt;

   assign shAmt = dx.opB[3:0];
   // Upper half of the doubled word is the rotated value
   assign rotWide = {dx.opA, dx.opA} << shAmt;

   always_comb begin
      case (dx.aluOp)
         pipePkg::ADD: aluOut = dx.opA + dx.opB;
         pipePkg::SUB: aluOut = dx.opA - dx.opB;
         pipePkg::XOR: aluOut = dx.opA ^ dx.opB;
         pipePkg::ANDN: aluOut = dx.opA & ~dx.opB;
         pipePkg::ROL: aluOut = rotWide[2*isaPkg::DataWidth-1:isaPkg::DataWidth];
         pipePkg::SLL: aluOut = dx.opA << shAmt;
         pipePkg::SLBI: aluOut = (dx.opA << 8) | dx.opB;
         default: aluOut = dx.opB;
      endcase
   end

   // Lets decode pick up this result one cycle before it is registered
   assign fwd = '{valid: dx.valid && dx.regWrite, dest: dx.dest, value: aluOut};

   always_ff @(posedge clk) begin
      if (rst) begin
         xr.valid <= 1'b0;
         xr.regWrite <= 1'b0;
         xr.halt <= 1'b0;
         xr.illegal <= 1'b0;
      end else begin
         xr.valid <= dx.valid;
         xr.regWrite <= dx.regWrite;
         xr.halt <= dx.halt;
         xr.illegal <= dx.illegal;
      end
      xr.dest <= dx.dest;
      xr.value <= aluOut;
   end

endmodule

// ==== result.sv ====
/*
 * Retires the execute result as a register write and a wb event.
 * halted and err are sticky until reset. The wb port has no ready.
 */
`timescale 1ns/1ps

module result (
   input  logic clk,
   input  logic rst,
   input  pipePkg::xrBundle_t xr,
   output logic wrEn,
   output logic [isaPkg::RegAddrWidth-1:0] wrAddr,
   output logic [isaPkg::DataWidth-1:0] wrData,
   output pipePkg::wbEvent_t wb,
   output logic halted,
   output logic err
);

   assign wrEn = xr.valid && xr.regWrite;
   assign wrAddr = xr.dest;
   assign wrData = xr.value;
   assign wb = '{valid: wrEn, regAddr: xr.dest, data: xr.value};

   always_ff @(posedge clk) begin
      if (rst) begin
         halted <= 1'b0;
         err <= 1'b0;
      end else begin
         if (xr.valid && xr.halt) begin
            halted <= 1'b1;
         end
         // only one error source in this core
         if (xr.valid && xr.illegal) begin
            err <= 1'b1;
         end
      end
   end

   // Decode must stop issuing once HALT is taken
   quietAfterHalt: assert property (@(posedge clk) disable iff (rst)
      halted |-> !wb.valid)
      else $error("result: write-back event after halt");

endmodule

// ==== proc.sv ====
/*
 * Core top level: instruction queue, register file and three stages.
 * Instructions arrive through the credit port only; the sender starts
 * with pipePkg::QueueDepth credits after reset.
 */
`timescale 1ns/1ps

module proc (
   input  logic clk,
   input  logic rst,
   input  logic cmdPush,
   input  isaPkg::instr_t cmdInstr,
   output logic cmdCredit,
   output pipePkg::wbEvent_t wb,
   output logic halted,
   output logic err
);

   logic pop;
   logic headValid;
   isaPkg::instr_t headInstr;
   logic [isaPkg::RegAddrWidth-1:0] rdAddrA;
   logic [isaPkg::RegAddrWidth-1:0] rdAddrB;
   logic [isaPkg::DataWidth-1:0] rdDataA;
   logic [isaPkg::DataWidth-1:0] rdDataB;
   logic wrEn;
   logic [isaPkg::RegAddrWidth-1:0] wrAddr;
   logic [isaPkg::DataWidth-1:0] wrData;
   pipePkg::fwdPath_t fwd;
   pipePkg::dxBundle_t dx;
   pipePkg::xrBundle_t xr;

   instrQueue queueSection (
      .clk(clk), .rst(rst), .cmdPush(cmdPush), .cmdInstr(cmdInstr),
      .pop(pop), .headValid(headValid), .headInstr(headInstr), .cmdCredit(cmdCredit)
   );

   regFile regFileSection (
      .clk(clk), .rst(rst), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
      .rdDataA(rdDataA), .rdDataB(rdDataB),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
   );

   // halted from result closes the loop back into decode
   decode decodeSection (
      .clk(clk), .rst(rst), .headValid(headValid), .headInstr(headInstr),
      .halted(halted), .pop(pop), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
      .rdDataA(rdDataA), .rdDataB(rdDataB), .fwd(fwd), .dx(dx)
   );

   execute executeSection (
      .clk(clk), .rst(rst), .dx(dx), .fwd(fwd), .xr(xr)
   );

   result resultSection (
      .clk(clk), .rst(rst), .xr(xr), .wrEn(wrEn), .wrAddr(wrAddr),
      .wrData(wrData), .wb(wb), .halted(halted), .err(err)
   );

endmodule

// ==== procTb.sv ====
/*
 * Testbench for the core. The reference model runs at push time and queues
 * the expected write-back events in program order.
 * Checks are concurrent assertions sampled on the falling clock edge.
 */
`timescale 1ns/1ps

module procTb;

   typedef struct packed {
      isaPkg::instr_t instr;
      logic burst;
      logic drain;
      logic [2:0] phase;
   } step_t;

   typedef struct packed {
      pipePkg::wbEvent_t ev;
      logic [2:0] phase;
   } expect_t;

   logic clk = 1'b0;
   logic rst;
   logic cmdPush;
   isaPkg::instr_t cmdInstr;
   logic cmdCredit;
   pipePkg::wbEvent_t wb;
   logic halted;
   logic err;

   integer seed = 32'h83c0;
   int credits;
   int wrIdx;
   int rdIdx = 0;
   int progLen = 0;
   int stuck;
   logic errExpected;
   logic haltExpected;
   logic [isaPkg::DataWidth-1:0] modelRegs [8];
   expect_t expEvents [256];
   step_t prog [$];

   proc u_dut (
      .clk(clk), .rst(rst), .cmdPush(cmdPush), .cmdInstr(cmdInstr),
      .cmdCredit(cmdCredit), .wb(wb), .halted(halted), .err(err)
   );

   always #10 clk = ~clk;

   task automatic stopRun();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] actVal);
      $display("** Error: %s expected %h actual %h", name, expVal, actVal);
      stopRun();
   endtask

   task automatic failNote(string why);
      $display("Failure: %s", why);
      stopRun();
   endtask

   function automatic string phaseName(logic [2:0] phase);
      case (phase)
         3'd1: return "register ALU";
         3'd2: return "immediates";
         3'd3: return "forwarding";
         3'd4: return "illegal and NOP";
         default: return "halt";
      endcase
   endfunction

   function automatic isaPkg::instr_t instrR(isaPkg::aluFunc_t f, logic [2:0] rd,
                                             logic [2:0] rs, logic [2:0] rt);
      isaPkg::instr_t w;
      w.r.opcode = isaPkg::ALUR;
      w.r.rs = rs;
      w.r.rt = rt;
      w.r.rd = rd;
      w.r.func = f;
      return w;
   endfunction

   function automatic isaPkg::instr_t instrI(isaPkg::opcode_t op, logic [2:0] rd,
                                             logic [2:0] rs, logic [4:0] imm5);
      isaPkg::instr_t w;
      w.i.opcode = op;
      w.i.rs = rs;
      w.i.rd = rd;
      w.i.imm5 = imm5;
      return w;
   endfunction

   function automatic isaPkg::instr_t instrB(isaPkg::opcode_t op, logic [2:0] rd,
                                             logic [7:0] imm8);
      isaPkg::instr_t w;
      w.bi.opcode = op;
      w.bi.rd = rd;
      w.bi.imm8 = imm8;
      return w;
   endfunction

   function automatic void addStep(isaPkg::instr_t w, logic burst, logic drain,
                                   logic [2:0] phase);
      step_t s;
      s.instr = w;
      s.burst = burst;
      s.drain = drain;
      s.phase = phase;
      prog.push_back(s);
   endfunction

   // Reference model of the ISA rules, applied in program order
   function automatic void modelApply(isaPkg::instr_t w, logic [2:0] phase);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] v;
      logic [15:0] sext5;
      logic [15:0] zext5;
      logic [2:0] dest;
      logic wr;
      int n;
      if (haltExpected) begin
         stuck++;
         return;
      end
      a = modelRegs[w.r.rs];
      b = modelRegs[w.r.rt];
      sext5 = {{11{w.i.imm5[4]}}, w.i.imm5};
      zext5 = {11'b0, w.i.imm5};
      n = int'(w.i.imm5[3:0]);
      dest = w.i.rd;
      wr = 1'b1;
      v = '0;
      case (w.r.opcode)
         isaPkg::ALUR: begin
            dest = w.r.rd;
            case (w.r.func)
               isaPkg::ADD: v = a + b;
               isaPkg::SUB: v = a - b;
               isaPkg::XOR: v = a ^ b;
               default: v = a & ~b;
            endcase
         end
         isaPkg::ADDI: v = a + sext5;
         isaPkg::SUBI: v = a - sext5;
         isaPkg::XORI: v = a ^ zext5;
         isaPkg::ANDNI: v = a & ~zext5;
         isaPkg::ROLI: v = (a << n) | (a >> (16 - n));
         isaPkg::SLLI: v = a << n;
         isaPkg::LBI: begin
            dest = w.bi.rd;
            v = {{8{w.bi.imm8[7]}}, w.bi.imm8};
         end
         isaPkg::SLBI: begin
            dest = w.bi.rd;
            v = {modelRegs[w.bi.rd][7:0], w.bi.imm8};
         end
         isaPkg::NOP: wr = 1'b0;
         isaPkg::HALT: begin
            wr = 1'b0;
            haltExpected = 1'b1;
         end
         default: begin
            wr = 1'b0;
            errExpected = 1'b1;
         end
      endcase
      if (wr) begin
         expEvents[wrIdx].ev.valid = 1'b1;
         expEvents[wrIdx].ev.regAddr = dest;
         expEvents[wrIdx].ev.data = v;
         expEvents[wrIdx].phase = phase;
         wrIdx++;
         modelRegs[dest] = v;
      end
   endfunction

   function automatic void buildProgram();
      isaPkg::opcode_t opsI [6] = '{isaPkg::ADDI, isaPkg::SUBI, isaPkg::XORI,
                                    isaPkg::ANDNI, isaPkg::ROLI, isaPkg::SLLI};
      logic [4:0] imm5s [4] = '{5'h00, 5'h10, 5'h1f, 5'h0f};
      logic [7:0] imm8s [4] = '{8'h00, 8'h7f, 8'h80, 8'hff};
      addStep(instrB(isaPkg::LBI, 3'd1, 8'hfd), 1'b0, 1'b0, 3'd1);
      addStep(instrB(isaPkg::LBI, 3'd2, 8'h45), 1'b0, 1'b0, 3'd1);
      addStep(instrB(isaPkg::LBI, 3'd3, 8'h80), 1'b0, 1'b0, 3'd1);
      for (int f = 0; f < 4; f++) begin
         addStep(instrR(isaPkg::aluFunc_t'(f), 3'(4 + f), 3'd1, 3'd2), 1'b0, 1'b0, 3'd1);
      end
      addStep(instrR(isaPkg::SUB, 3'd0, 3'd3, 3'd1), 1'b0, 1'b1, 3'd1);
      for (int i = 0; i < 6; i++) begin
         for (int j = 0; j < 4; j++) begin
            addStep(instrI(opsI[i], 3'(i + j), 3'(j + 1), imm5s[j]), 1'b0, 1'b0, 3'd2);
         end
      end
      for (int j = 0; j < 4; j++) begin
         addStep(instrB(isaPkg::LBI, 3'(j), imm8s[j]), 1'b0, 1'b0, 3'd2);
         addStep(instrB(isaPkg::SLBI, 3'(j), imm8s[3 - j]), 1'b0, j == 3, 3'd2);
      end
      // Each step reads the two previous destinations
      for (int i = 2; i < 22; i++) begin
         if (i % 4 == 0) begin
            addStep(instrI(isaPkg::ADDI, 3'(i), 3'(i - 1), 5'($random(seed))),
                    1'b1, 1'b0, 3'd3);
         end else begin
            addStep(instrR(isaPkg::aluFunc_t'($random(seed)), 3'(i), 3'(i - 1), 3'(i - 2)),
                    1'b1, i == 21, 3'd3);
         end
      end
      addStep(instrB(isaPkg::LBI, 3'd2, 8'h33), 1'b0, 1'b0, 3'd4);
      addStep(isaPkg::instr_t'(16'hf8e5), 1'b0, 1'b0, 3'd4);
      addStep(isaPkg::instr_t'(16'h0800), 1'b0, 1'b0, 3'd4);
      addStep(instrI(isaPkg::ADDI, 3'd3, 3'd2, 5'h05), 1'b0, 1'b0, 3'd4);
      addStep(isaPkg::instr_t'(16'h0800), 1'b0, 1'b0, 3'd4);
      addStep(instrR(isaPkg::ADD, 3'd4, 3'd3, 3'd2), 1'b0, 1'b1, 3'd4);
      // Three words stay in the queue behind HALT
      addStep(instrB(isaPkg::LBI, 3'd5, 8'h5a), 1'b1, 1'b0, 3'd5);
      addStep(isaPkg::instr_t'(16'h0000), 1'b1, 1'b0, 3'd5);
      addStep(instrB(isaPkg::LBI, 3'd6, 8'h11), 1'b1, 1'b0, 3'd5);
      addStep(instrI(isaPkg::ADDI, 3'd1, 3'd5, 5'h01), 1'b1, 1'b0, 3'd5);
      addStep(instrR(isaPkg::ADD, 3'd2, 3'd5, 3'd5), 1'b1, 1'b0, 3'd5);
   endfunction

   task automatic stepCycle();
      @(posedge clk);
      #1;
      if (cmdCredit) begin
         credits++;
      end
   endtask

   task automatic drainQueue();
      int waited;
      waited = 0;
      while (credits != pipePkg::QueueDepth) begin
         if (waited == 100) begin
            failNote("credits did not return to the queue depth after draining");
         end
         stepCycle();
         waited++;
      end
      // The last popped word retires three edges later
      repeat (3) stepCycle();
      drainRetired: assert (rdIdx == wrIdx)
         else reportMismatch("drain", 32'(wrIdx), 32'(rdIdx));
   endtask

   task automatic pushStep(step_t s);
      int gap;
      gap = s.burst ? 0 : int'($unsigned($random(seed)) % 3);
      repeat (gap) stepCycle();
      while (credits == 0) begin
         stepCycle();
      end
      cmdPush = 1'b1;
      cmdInstr = s.instr;
      credits--;
      modelApply(s.instr, s.phase);
      stepCycle();
      cmdPush = 1'b0;
      if (s.drain) begin
         drainQueue();
      end
   endtask

   // Retire pointer moves on the edge that ends a wb cycle
   always @(posedge clk) begin
      if (!rst && wb.valid) begin
         rdIdx <= rdIdx + 1;
      end
   end

   wbExpected: assert property (@(negedge clk) disable iff (rst)
      wb.valid |-> rdIdx < wrIdx)
      else failNote("a write-back event appeared with none expected");

   wbMatches: assert property (@(negedge clk) disable iff (rst)
      (wb.valid && rdIdx < wrIdx) |-> wb == expEvents[rdIdx].ev)
      else reportMismatch(phaseName(expEvents[rdIdx].phase), 32'(expEvents[rdIdx].ev), 32'(wb));

   creditRange: assert property (@(negedge clk)
      credits >= 0 && credits <= pipePkg::QueueDepth)
      else failNote("the credit counter left the range zero to queue depth");

   creditQuietInReset: assert property (@(negedge clk) rst |-> !cmdCredit)
      else failNote("cmdCredit pulsed during reset");

   errOnlyAfterIllegal: assert property (@(negedge clk) disable iff (rst)
      !errExpected |-> !err)
      else reportMismatch("illegal and NOP", 32'd0, 32'(err));

   errSticky: assert property (@(negedge clk) disable iff (rst) $past(err) |-> err)
      else failNote("err dropped before reset");

   haltOnlyAfterHalt: assert property (@(negedge clk) disable iff (rst)
      !haltExpected |-> !halted)
      else reportMismatch("halt", 32'd0, 32'(halted));

   haltSticky: assert property (@(negedge clk) disable iff (rst)
      $past(halted) |-> (halted && !cmdCredit))
      else failNote("halted dropped or a credit returned after halt");

   initial begin
      int waited;
      rst = 1'b1;
      cmdPush = 1'b0;
      cmdInstr = '0;
      credits = pipePkg::QueueDepth;
      wrIdx = 0;
      stuck = 0;
      errExpected = 1'b0;
      haltExpected = 1'b0;
      foreach (modelRegs[r]) begin
         modelRegs[r] = '0;
      end
      buildProgram();
      progLen = prog.size();
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (prog[i]) begin
         pushStep(prog[i]);
      end
      waited = 0;
      while (!halted) begin
         if (waited == 50) begin
            failNote("halted did not rise after HALT was pushed");
         end
         stepCycle();
         waited++;
      end
      // Quiet period to show nothing retires behind HALT
      repeat (20) stepCycle();
      errFinal: assert (err)
         else reportMismatch("illegal and NOP", 32'd1, 32'(err));
      creditFinal: assert (credits == pipePkg::QueueDepth - stuck)
         else reportMismatch("halt", 32'(pipePkg::QueueDepth - stuck), 32'(credits));
      retireFinal: assert (rdIdx == wrIdx)
         else reportMismatch("halt", 32'(wrIdx), 32'(rdIdx));
      $display("All tests passed");
      $finish;
   end

   initial begin
      wait (progLen != 0);
      repeat (40 * progLen + 200) @(posedge clk);
      failNote("the watchdog expired before the tests finished");
   end

endmodule

// ==== vlog.f ====
isaPkg.sv
pipePkg.sv
instrQueue.sv
regFile.sv
decode.sv
execute.sv
result.sv
proc.sv
procTb.sv

// ==== Makefile ====
TOP = procTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o simv
	-./obj_dir/simv > sim.log 2>&1
	@cat sim.log
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
